// ==== design/mdio_pkg.sv ====
package mdio_pkg;

    // Frame geometry for a clause 22 management frame
    localparam int MDIO_PREAMBLE_BITS = 32;
    localparam int MDIO_FRAME_BITS    = 32;

    localparam int MDIO_PHY_ADDR_W = 5;
    localparam int MDIO_REG_ADDR_W = 5;
    localparam int MDIO_DATA_W     = 16;

    // Fixed frame codes
    localparam logic [1:0] MDIO_ST_CLAUSE22 = 2'b01;
    localparam logic [1:0] MDIO_OP_WRITE    = 2'b01;
    localparam logic [1:0] MDIO_TA_WRITE    = 2'b10;

    // Fields in transmit order with the first wire bit as MSB
    typedef struct packed {
        logic [1:0]                 st;
        logic [1:0]                 op;
        logic [MDIO_PHY_ADDR_W-1:0] phy_addr;
        logic [MDIO_REG_ADDR_W-1:0] reg_addr;
        logic [1:0]                 ta;
        logic [MDIO_DATA_W-1:0]     data;
    } mdio_frame_fields_t;

    // Built through the fields and shifted out as a raw word
    typedef union packed {
        mdio_frame_fields_t         fields;
        logic [MDIO_FRAME_BITS-1:0] raw;
    } mdio_frame_u;

endpackage

// ==== design/phy_init_pkg.sv ====
package phy_init_pkg;

    // Direct registers used for indirect extended access
    localparam logic [mdio_pkg::MDIO_REG_ADDR_W-1:0] REGCR_ADDR = 5'h0D;
    localparam logic [mdio_pkg::MDIO_REG_ADDR_W-1:0] ADDAR_ADDR = 5'h0E;

    // Vendor specific MMD
    localparam logic [4:0] MMD_DEVAD = 5'h1F;

    // REGCR bits 15:14 select the function and bits 4:0 carry DEVAD
    localparam logic [15:0] REGCR_FUNC_ADDR = {2'b00, 9'd0, MMD_DEVAD};
    localparam logic [15:0] REGCR_FUNC_DATA = {2'b01, 9'd0, MMD_DEVAD};

    typedef struct packed {
        logic [15:0] addr;
        logic [15:0] value;
    } ext_write_t;

    // One direct write for the MDIO master
    typedef struct packed {
        logic [mdio_pkg::MDIO_REG_ADDR_W-1:0] reg_addr;
        logic [mdio_pkg::MDIO_DATA_W-1:0]     data;
    } mdio_cmd_t;

    localparam int NUM_EXT_WRITES = 3;

    localparam ext_write_t EXT_WRITE_LIST [NUM_EXT_WRITES] = '{
        // CFG4 sets the SGMII autonegotiation timer to 11 ms
        '{addr: 16'h0031, value: 16'h0070},
        // SGMIICTL1 enables the SGMII clock output
        '{addr: 16'h00D3, value: 16'h4000},
        // 10M_SGMII_CFG allows 10 Mbps operation
        '{addr: 16'h016F, value: 16'h0015}
    };

endpackage

// ==== design/phy_init_sequencer.sv ====
`timescale 1ns/10ps

module phy_init_sequencer #(
    parameter int unsigned STARTUP_DELAY = 1048575
) (
    input  logic                     clk_125mhz_int,
    input  logic                     rst_125mhz_int,
    output phy_init_pkg::ext_write_t ext_o,
    output logic                     ext_valid_o,
    input  logic                     ext_ready_i,
    output logic                     init_done_o
);

    import phy_init_pkg::*;

    localparam int DELAY_W = (STARTUP_DELAY > 1) ? $clog2(STARTUP_DELAY + 1) : 1;
    localparam int IDX_W   = (NUM_EXT_WRITES > 1) ? $clog2(NUM_EXT_WRITES) : 1;

    logic [DELAY_W-1:0] delay_cnt;
    logic [IDX_W-1:0]   idx;
    logic               ext_valid_q;
    logic               list_done;
    logic               init_done_q;

    always_ff @(posedge clk_125mhz_int) begin
        if (rst_125mhz_int) begin
            delay_cnt   <= DELAY_W'(STARTUP_DELAY);
            idx         <= '0;
            ext_valid_q <= 1'b0;
            list_done   <= 1'b0;
            init_done_q <= 1'b0;
        end else if (delay_cnt != '0) begin
            // Give the PHY time to come out of its own reset
            delay_cnt <= delay_cnt - 1'b1;
        end else if (ext_valid_q) begin
            if (ext_ready_i) begin
                if (idx == IDX_W'(NUM_EXT_WRITES - 1)) begin
                    ext_valid_q <= 1'b0;
                    list_done   <= 1'b1;
                end else begin
                    // Next entry follows straight away
                    idx <= idx + 1'b1;
                end
            end
        end else if (!list_done) begin
            ext_valid_q <= 1'b1;
        end else if (ext_ready_i) begin
            // Idle expander means the last write has been handed on
            init_done_q <= 1'b1;
        end
    end

    assign ext_o       = EXT_WRITE_LIST[idx];
    assign ext_valid_o = ext_valid_q;
    assign init_done_o = init_done_q;

endmodule

// ==== design/ext_reg_expander.sv ====
`timescale 1ns/10ps

module ext_reg_expander (
    input  logic                     clk_125mhz_int,
    input  logic                     rst_125mhz_int,
    input  phy_init_pkg::ext_write_t ext_i,
    input  logic                     ext_valid_i,
    output logic                     ext_ready_o,
    output phy_init_pkg::mdio_cmd_t  cmd_o,
    output logic                     cmd_valid_o,
    input  logic                     cmd_ready_i
);

    import phy_init_pkg::*;

    logic       busy;
    logic [1:0] step;
    logic       cmd_valid_q;
    ext_write_t ext_q;

    always_ff @(posedge clk_125mhz_int) begin
        if (rst_125mhz_int) begin
            busy        <= 1'b0;
            step        <= 2'd0;
            cmd_valid_q <= 1'b0;
        end else if (!busy) begin
            if (ext_valid_i) begin
                busy        <= 1'b1;
                step        <= 2'd0;
                cmd_valid_q <= 1'b1;
            end
        end else if (cmd_valid_q && cmd_ready_i) begin
            if (step == 2'd3) begin
                cmd_valid_q <= 1'b0;
                busy        <= 1'b0;
            end else begin
                step <= step + 2'd1;
            end
        end
    end

    // Captured write is loaded only on acceptance
    always_ff @(posedge clk_125mhz_int) begin
        if (!busy && ext_valid_i) begin
            ext_q <= ext_i;
        end
    end

    // Indirect access through REGCR and ADDAR
    always_comb begin
        case (step)
            2'd0: begin
                cmd_o.reg_addr = REGCR_ADDR;
                cmd_o.data     = REGCR_FUNC_ADDR;
            end
            2'd1: begin
                cmd_o.reg_addr = ADDAR_ADDR;
                cmd_o.data     = ext_q.addr;
            end
            2'd2: begin
                cmd_o.reg_addr = REGCR_ADDR;
                cmd_o.data     = REGCR_FUNC_DATA;
            end
            default: begin
                cmd_o.reg_addr = ADDAR_ADDR;
                cmd_o.data     = ext_q.value;
            end
        endcase
    end

    assign ext_ready_o = !busy;
    assign cmd_valid_o = cmd_valid_q;

endmodule

// ==== design/mdio_frame_shifter.sv ====
`timescale 1ns/10ps

module mdio_frame_shifter #(
    parameter int                                    PRESCALE = 3,
    parameter logic [mdio_pkg::MDIO_PHY_ADDR_W-1:0] PHY_ADDR = 3
) (
    input  logic                    clk_125mhz_int,
    input  logic                    rst_125mhz_int,
    input  phy_init_pkg::mdio_cmd_t cmd_i,
    input  logic                    cmd_valid_i,
    output logic                    cmd_ready_o,
    output logic                    mdc_o,
    output logic                    mdio_o,
    output logic                    mdio_oe_o
);

    import mdio_pkg::*;

    localparam int TOTAL_BITS = MDIO_PREAMBLE_BITS + MDIO_FRAME_BITS;
    localparam int BIT_W      = $clog2(TOTAL_BITS);
    localparam int PRESC_W    = (PRESCALE > 0) ? $clog2(PRESCALE + 1) : 1;

    logic               busy;
    logic [PRESC_W-1:0] presc_cnt;
    logic [BIT_W-1:0]   bit_cnt;
    logic               mdc_q;
    logic               mdio_q;
    logic               mdio_oe_q;
    mdio_frame_u        frame_q;

    always_ff @(posedge clk_125mhz_int) begin
        if (rst_125mhz_int) begin
            busy      <= 1'b0;
            presc_cnt <= '0;
            bit_cnt   <= '0;
            mdc_q     <= 1'b0;
            mdio_q    <= 1'b0;
            mdio_oe_q <= 1'b0;
        end else if (!busy) begin
            if (cmd_valid_i) begin
                // First preamble bit goes out with MDC low
                busy      <= 1'b1;
                presc_cnt <= '0;
                bit_cnt   <= '0;
                mdio_q    <= 1'b1;
                mdio_oe_q <= 1'b1;
            end
        end else if (presc_cnt != PRESC_W'(PRESCALE)) begin
            presc_cnt <= presc_cnt + 1'b1;
        end else begin
            presc_cnt <= '0;
            mdc_q     <= !mdc_q;
            if (mdc_q) begin
                // Falling edge ends a bit period
                if (bit_cnt == BIT_W'(TOTAL_BITS - 1)) begin
                    busy      <= 1'b0;
                    mdio_q    <= 1'b0;
                    mdio_oe_q <= 1'b0;
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                    if (bit_cnt >= BIT_W'(MDIO_PREAMBLE_BITS - 1)) begin
                        mdio_q <= frame_q.raw[MDIO_FRAME_BITS-1];
                    end
                end
            end
        end
    end

    // Frame word is loaded field by field and then shifted MSB first
    always_ff @(posedge clk_125mhz_int) begin
        if (!busy && cmd_valid_i) begin
            frame_q.fields.st       <= MDIO_ST_CLAUSE22;
            frame_q.fields.op       <= MDIO_OP_WRITE;
            frame_q.fields.phy_addr <= PHY_ADDR;
            frame_q.fields.reg_addr <= cmd_i.reg_addr;
            frame_q.fields.ta       <= MDIO_TA_WRITE;
            frame_q.fields.data     <= cmd_i.data;
        end else if (busy && mdc_q && presc_cnt == PRESC_W'(PRESCALE) &&
                     bit_cnt >= BIT_W'(MDIO_PREAMBLE_BITS - 1) &&
                     bit_cnt != BIT_W'(TOTAL_BITS - 1)) begin
            frame_q.raw <= {frame_q.raw[MDIO_FRAME_BITS-2:0], 1'b0};
        end
    end

    assign cmd_ready_o = !busy;
    assign mdc_o       = mdc_q;
    assign mdio_o      = mdio_q;
    assign mdio_oe_o   = mdio_oe_q;

endmodule

// ==== design/phy_mgmt_top.sv ====
`timescale 1ns/10ps

module phy_mgmt_top #(
    parameter int unsigned                           STARTUP_DELAY = 1048575,
    parameter int                                    PRESCALE      = 3,
    parameter logic [mdio_pkg::MDIO_PHY_ADDR_W-1:0] PHY_ADDR      = 3
) (
    input  logic clk_125mhz_int,
    input  logic rst_125mhz_int,
    output logic phy_mdc_o,
    output logic phy_mdio_o,
    output logic phy_mdio_oe_o,
    output logic init_done_o
);

    import phy_init_pkg::*;

    ext_write_t ext;
    logic       ext_valid;
    logic       ext_ready;
    mdio_cmd_t  cmd;
    logic       cmd_valid;
    logic       cmd_ready;

    phy_init_sequencer #(
        .STARTUP_DELAY(STARTUP_DELAY)
    ) i_sequencer (
        .clk_125mhz_int(clk_125mhz_int),
        .rst_125mhz_int(rst_125mhz_int),
        .ext_o         (ext),
        .ext_valid_o   (ext_valid),
        .ext_ready_i   (ext_ready),
        .init_done_o   (init_done_o)
    );

    ext_reg_expander i_expander (
        .clk_125mhz_int(clk_125mhz_int),
        .rst_125mhz_int(rst_125mhz_int),
        .ext_i         (ext),
        .ext_valid_i   (ext_valid),
        .ext_ready_o   (ext_ready),
        .cmd_o         (cmd),
        .cmd_valid_o   (cmd_valid),
        .cmd_ready_i   (cmd_ready)
    );

    // Write only MDIO master on the pins
    mdio_frame_shifter #(
        .PRESCALE(PRESCALE),
        .PHY_ADDR(PHY_ADDR)
    ) i_shifter (
        .clk_125mhz_int(clk_125mhz_int),
        .rst_125mhz_int(rst_125mhz_int),
        .cmd_i         (cmd),
        .cmd_valid_i   (cmd_valid),
        .cmd_ready_o   (cmd_ready),
        .mdc_o         (phy_mdc_o),
        .mdio_o        (phy_mdio_o),
        .mdio_oe_o     (phy_mdio_oe_o)
    );

endmodule

// ==== verif/mdio_phy_model.sv ====
`timescale 1ns/10ps

module mdio_phy_model (
    input  logic                                    clk_125mhz_int,
    input  logic                                    rst_125mhz_int,
    input  logic                                    mdc_i,
    input  logic                                    mdio_i,
    input  logic                                    mdio_oe_i,
    output logic                                    frame_strobe_o,
    output logic [mdio_pkg::MDIO_PREAMBLE_BITS-1:0] preamble_o,
    output mdio_pkg::mdio_frame_fields_t            frame_o
);

    import mdio_pkg::*;

    localparam int TOTAL_BITS = MDIO_PREAMBLE_BITS + MDIO_FRAME_BITS;

    logic                  mdc_q;
    logic                  mdc_rise;
    logic [TOTAL_BITS-1:0] bits_q;
    logic [TOTAL_BITS-1:0] next_bits;
    int unsigned           bit_cnt;

    // The PHY samples MDIO on the rising MDC edge
    assign mdc_rise  = mdc_i && !mdc_q;
    assign next_bits = {bits_q[TOTAL_BITS-2:0], mdio_i};

    always_ff @(posedge clk_125mhz_int) begin
        if (rst_125mhz_int) begin
            mdc_q          <= 1'b0;
            bits_q         <= '0;
            bit_cnt        <= 0;
            frame_strobe_o <= 1'b0;
            preamble_o     <= '0;
            frame_o        <= '0;
        end else begin
            mdc_q          <= mdc_i;
            frame_strobe_o <= 1'b0;
            if (!mdio_oe_i) begin
                // Released line drops any partial frame
                bit_cnt <= 0;
            end else if (mdc_rise) begin
                bits_q <= next_bits;
                if (bit_cnt == TOTAL_BITS - 1) begin
                    bit_cnt        <= 0;
                    frame_strobe_o <= 1'b1;
                    preamble_o     <= next_bits[TOTAL_BITS-1 -: MDIO_PREAMBLE_BITS];
                    frame_o        <= mdio_frame_fields_t'(next_bits[MDIO_FRAME_BITS-1:0]);
                end else begin
                    bit_cnt <= bit_cnt + 1;
                end
            end
        end
    end

endmodule

// ==== verif/tb_phy_mgmt.sv ====
`timescale 1ns/10ps

module tb_phy_mgmt;

    import mdio_pkg::*;
    import phy_init_pkg::*;

    localparam int unsigned STARTUP_DELAY = 20;
    localparam int          PRESCALE      = 3;
    localparam logic [MDIO_PHY_ADDR_W-1:0] PHY_ADDR = 5'd3;

    localparam int NUM_FRAMES = 4 * NUM_EXT_WRITES;

    // Indirect access words of the PHY register map
    localparam logic [4:0]  REGCR      = 5'h0D;
    localparam logic [4:0]  ADDAR      = 5'h0E;
    localparam logic [15:0] CTRL_ADDR  = 16'h001F;
    localparam logic [15:0] CTRL_DATA  = 16'h401F;

    // Delay plus 12 frames of 64 bits at 8 clocks is about 6200 cycles
    localparam int unsigned MAX_CYCLES   = 8000;
    localparam int unsigned QUIET_CYCLES = 200;

    logic               clk_125mhz_int;
    logic               rst_125mhz_int;
    logic               phy_mdc;
    logic               phy_mdio;
    logic               phy_mdio_oe;
    logic               init_done;
    logic               frame_strobe;
    logic [31:0]        preamble;
    mdio_frame_fields_t frame;

    mdio_cmd_t   exp_q[$];
    mdio_cmd_t   exp_cmd;
    int unsigned cycle_cnt       = 0;
    int unsigned post_rst_cycles = 0;
    int unsigned phase_len       = 0;
    int unsigned frames_started  = 0;
    int unsigned frames_ended    = 0;
    int unsigned frames_seen     = 0;
    logic        last_mdc;
    logic        last_oe;
    logic        last_init_done;

    phy_mgmt_top #(
        .STARTUP_DELAY(STARTUP_DELAY),
        .PRESCALE     (PRESCALE),
        .PHY_ADDR     (PHY_ADDR)
    ) i_dut (
        .clk_125mhz_int(clk_125mhz_int),
        .rst_125mhz_int(rst_125mhz_int),
        .phy_mdc_o     (phy_mdc),
        .phy_mdio_o    (phy_mdio),
        .phy_mdio_oe_o (phy_mdio_oe),
        .init_done_o   (init_done)
    );

    mdio_phy_model i_phy (
        .clk_125mhz_int(clk_125mhz_int),
        .rst_125mhz_int(rst_125mhz_int),
        .mdc_i         (phy_mdc),
        .mdio_i        (phy_mdio),
        .mdio_oe_i     (phy_mdio_oe),
        .frame_strobe_o(frame_strobe),
        .preamble_o    (preamble),
        .frame_o       (frame)
    );

    always #4 clk_125mhz_int = ~clk_125mhz_int;

    task automatic stop_on_failure();
        $display("TEST FAILED");
        $fatal(1, "run stopped at first failure");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("mismatch at %0t: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
        stop_on_failure();
    endtask

    // Four direct writes per extended write
    task automatic build_expected();
        mdio_cmd_t cmd;
        for (int i = 0; i < NUM_EXT_WRITES; i++) begin
            cmd.reg_addr = REGCR;
            cmd.data     = CTRL_ADDR;
            exp_q.push_back(cmd);
            cmd.reg_addr = ADDAR;
            cmd.data     = EXT_WRITE_LIST[i].addr;
            exp_q.push_back(cmd);
            cmd.reg_addr = REGCR;
            cmd.data     = CTRL_DATA;
            exp_q.push_back(cmd);
            cmd.reg_addr = ADDAR;
            cmd.data     = EXT_WRITE_LIST[i].value;
            exp_q.push_back(cmd);
        end
    endtask

    always @(posedge clk_125mhz_int) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("timeout: initialization not finished after %0d cycles", MAX_CYCLES);
            stop_on_failure();
        end
    end

    // Quiet pins during reset and the startup delay
    always @(posedge clk_125mhz_int) begin
        if (!rst_125mhz_int) begin
            post_rst_cycles <= post_rst_cycles + 1;
        end
        if (cycle_cnt > 0 && (rst_125mhz_int || post_rst_cycles < STARTUP_DELAY)) begin
            assert (phy_mdc == 1'b0) else report_mismatch("phy_mdc_o", phy_mdc, 0);
            assert (phy_mdio_oe == 1'b0) else report_mismatch("phy_mdio_oe_o", phy_mdio_oe, 0);
            assert (init_done == 1'b0) else report_mismatch("init_done_o", init_done, 0);
        end
    end

    // MDC phase lengths, frame starts and ends, init_done_o rise
    always @(posedge clk_125mhz_int) begin
        if (rst_125mhz_int) begin
            last_mdc       <= 1'b0;
            last_oe        <= 1'b0;
            last_init_done <= 1'b0;
            phase_len      <= 0;
        end else begin
            if (last_oe && (phy_mdc != last_mdc || !phy_mdio_oe)) begin
                assert (phase_len == PRESCALE + 1)
                    else report_mismatch("MDC phase length", phase_len, PRESCALE + 1);
            end
            if (phy_mdio_oe && last_oe && phy_mdc == last_mdc) begin
                phase_len <= phase_len + 1;
            end else begin
                phase_len <= 1;
            end
            if (phy_mdio_oe && !last_oe) begin
                if (frames_started >= NUM_FRAMES) begin
                    $display("error at %0t: MDIO enabled again after the last frame", $time);
                    stop_on_failure();
                end
                frames_started <= frames_started + 1;
            end
            if (!phy_mdio_oe && last_oe) begin
                frames_ended <= frames_ended + 1;
            end
            // Done follows the hand-over of the last direct write
            if (init_done && !last_init_done) begin
                assert (frames_started == NUM_FRAMES)
                    else report_mismatch("frames begun at init_done_o rise",
                                         frames_started, NUM_FRAMES);
            end
            last_mdc       <= phy_mdc;
            last_oe        <= phy_mdio_oe;
            last_init_done <= init_done;
        end
    end

    // Decoded frame against the expansion of the write list
    always @(posedge clk_125mhz_int) begin
        if (!rst_125mhz_int && frame_strobe === 1'b1) begin
            assert (preamble == '1) else report_mismatch("preamble", preamble, '1);
            assert (frame.st == 2'b01) else report_mismatch("start code", frame.st, 2'b01);
            assert (frame.op == 2'b01) else report_mismatch("opcode", frame.op, 2'b01);
            assert (frame.phy_addr == PHY_ADDR)
                else report_mismatch("PHY address", frame.phy_addr, PHY_ADDR);
            assert (frame.ta == 2'b10) else report_mismatch("turnaround", frame.ta, 2'b10);
            if (exp_q.size() == 0) begin
                $display("error at %0t: frame received with none left to expect", $time);
                stop_on_failure();
            end else begin
                exp_cmd = exp_q.pop_front();
                assert (frame.reg_addr == exp_cmd.reg_addr)
                    else report_mismatch("register address", frame.reg_addr, exp_cmd.reg_addr);
                assert (frame.data == exp_cmd.data)
                    else report_mismatch("register data", frame.data, exp_cmd.data);
                frames_seen <= frames_seen + 1;
            end
        end
    end

    // MDIO only moves while MDC is low
    assert property (@(posedge clk_125mhz_int) disable iff (rst_125mhz_int)
        $changed(phy_mdio) |-> !phy_mdc)
        else report_mismatch("phy_mdc_o at MDIO change", phy_mdc, 0);

    assert property (@(posedge clk_125mhz_int) disable iff (rst_125mhz_int)
        init_done |=> init_done)
        else report_mismatch("init_done_o", init_done, 1);

    initial begin
        clk_125mhz_int = 1'b0;
        rst_125mhz_int = 1'b1;
        build_expected();
        repeat (4) @(posedge clk_125mhz_int);
        rst_125mhz_int <= 1'b0;

        while (!(init_done === 1'b1 && frames_ended == NUM_FRAMES)) begin
            @(posedge clk_125mhz_int);
        end
        // Bus must stay idle after the last frame
        repeat (QUIET_CYCLES) @(posedge clk_125mhz_int);

        if (frames_seen == NUM_FRAMES && exp_q.size() == 0) begin
            $display("TEST PASSED");
            $finish;
        end else begin
            report_mismatch("frames decoded", frames_seen, NUM_FRAMES);
        end
    end

endmodule

// ==== build.f ====
design/mdio_pkg.sv
design/phy_init_pkg.sv
design/phy_init_sequencer.sv
design/ext_reg_expander.sv
design/mdio_frame_shifter.sv
design/phy_mgmt_top.sv
verif/mdio_phy_model.sv
verif/tb_phy_mgmt.sv

// ==== Bender.yml ====
package:
  name: phy_mgmt

sources:
  - design/mdio_pkg.sv
  - design/phy_init_pkg.sv
  - design/phy_init_sequencer.sv
  - design/ext_reg_expander.sv
  - design/mdio_frame_shifter.sv
  - design/phy_mgmt_top.sv
  - target: test
    files:
      - verif/mdio_phy_model.sv
      - verif/tb_phy_mgmt.sv
